// File: source/comp_pkg.sv
// Compressor shared types
`default_nettype none

package comp_pkg;

    // Sample path
    typedef logic signed [15:0] sample_t;   // Signed PCM, -32768 not supported
    typedef logic [15:0] mag_t;             // Magnitude of a sample, bit 15 stays clear

    // Threshold and gain
    typedef logic [3:0] thresh_t;           // Code k means magnitude k * 2048
    typedef logic [19:0] product_t;         // 16-bit magnitude times 4-bit factor

    // Threshold code sits at this bit of a magnitude word
    localparam int THRESH_LSB = 11;

endpackage : comp_pkg

`default_nettype wire

// File: source/cla_adder.sv
// Carry-lookahead adder
`default_nettype none

module cla_adder #(
    parameter int WIDTH = 16                    // Operand width
) (
    input wire [WIDTH-1:0] a,                   // First operand
    input wire [WIDTH-1:0] b,                   // Second operand
    input wire cin,                             // Carry into bit 0
    output logic [WIDTH-1:0] sum                // a + b + cin, carry out dropped
);

    localparam int NGROUPS = (WIDTH + 3) / 4;   // Number of 4-bit lookahead groups
    localparam int PWIDTH = NGROUPS * 4;        // Width padded to whole groups

    logic [PWIDTH-1:0] a_ext;                   // Zero padded operands
    logic [PWIDTH-1:0] b_ext;
    logic [PWIDTH-1:0] g;                       // Bit generate
    logic [PWIDTH-1:0] p;                       // Bit propagate
    logic [PWIDTH-1:0] c;                       // Carry into each bit
    logic [PWIDTH-1:0] sum_ext;
    logic [NGROUPS-1:0] grp_g;                  // Group generate
    logic [NGROUPS-1:0] grp_p;                  // Group propagate
    logic [NGROUPS-1:0] grp_c;                  // Carry into each group

    assign a_ext = PWIDTH'(a);
    assign b_ext = PWIDTH'(b);
    assign g = a_ext & b_ext;
    assign p = a_ext ^ b_ext;

    // Lookahead across groups, flat sum of products for every group carry
    always_comb begin
        logic carry;
        logic term;
        grp_c[0] = cin;
        for (int j = 1; j < NGROUPS; j++) begin
            carry = cin;
            for (int m = 0; m < j; m++) carry = carry & grp_p[m];    // cin through all groups
            for (int k = 0; k < j; k++) begin
                term = grp_g[k];                                      // Generated in group k
                for (int m = k + 1; m < j; m++) term = term & grp_p[m];
                carry = carry | term;
            end
            grp_c[j] = carry;
        end
    end

    // Lookahead inside each 4-bit group
    for (genvar gi = 0; gi < NGROUPS; gi++) begin : g_grp
        localparam int BASE = gi * 4;           // Lowest bit of this group
        assign c[BASE] = grp_c[gi];
        assign c[BASE+1] = g[BASE] | (p[BASE] & grp_c[gi]);
        assign c[BASE+2] = g[BASE+1] | (p[BASE+1] & g[BASE])
                         | (p[BASE+1] & p[BASE] & grp_c[gi]);
        assign c[BASE+3] = g[BASE+2] | (p[BASE+2] & g[BASE+1])
                         | (p[BASE+2] & p[BASE+1] & g[BASE])
                         | (p[BASE+2] & p[BASE+1] & p[BASE] & grp_c[gi]);
        assign grp_g[gi] = g[BASE+3] | (p[BASE+3] & g[BASE+2])
                         | (p[BASE+3] & p[BASE+2] & g[BASE+1])
                         | (p[BASE+3] & p[BASE+2] & p[BASE+1] & g[BASE]);
        assign grp_p[gi] = &p[BASE+3:BASE];     // Whole group passes carry
    end

    assign sum_ext = p ^ c;
    assign sum = sum_ext[WIDTH-1:0];            // Drop the padding

endmodule : cla_adder

`default_nettype wire

// File: source/gain_multiplier.sv
// Unsigned 16x4 gain multiplier
`default_nettype none

module gain_multiplier (
    input wire comp_pkg::mag_t mag,             // Magnitude of the oldest sample
    input wire [3:0] factor,                    // Excess bits above the threshold
    output comp_pkg::product_t product          // mag * factor, never overflows 20 bits
);

    comp_pkg::product_t pp [4];                 // Shifted partial products
    comp_pkg::product_t sum01;                  // pp0 + pp1
    comp_pkg::product_t sum012;                 // pp0 + pp1 + pp2

    // One partial product per factor bit, gated by that bit
    for (genvar i = 0; i < 4; i++) begin : g_pp
        assign pp[i] = factor[i] ? (comp_pkg::product_t'(mag) << i) : '0;
    end

    cla_adder #(.WIDTH(20)) u_add01 (
        .a   (pp[0]),
        .b   (pp[1]),
        .cin (1'b0),
        .sum (sum01)
    );

    cla_adder #(.WIDTH(20)) u_add012 (
        .a   (sum01),
        .b   (pp[2]),
        .cin (1'b0),
        .sum (sum012)
    );

    // Last stage gives the full product
    cla_adder #(.WIDTH(20)) u_add0123 (
        .a   (sum012),
        .b   (pp[3]),
        .cin (1'b0),
        .sum (product)
    );

endmodule : gain_multiplier

`default_nettype wire

// File: source/window_peak.sv
// Sample window and peak detector
`default_nettype none

module window_peak #(
    parameter int WINDOW_DEPTH = 4                  // Taps in the window, at least 2
) (
    input wire clk,
    input wire arst_n,
    input wire comp_pkg::sample_t sample,           // New sample, one per clock
    output comp_pkg::sample_t oldest,               // Last tap, raw
    output comp_pkg::mag_t oldest_mag,              // Magnitude of the last tap
    output comp_pkg::mag_t peak                     // Largest magnitude in the window
);

    localparam int NODES = 2 * WINDOW_DEPTH - 1;    // Leaves plus comparison nodes

    comp_pkg::sample_t taps [WINDOW_DEPTH];         // taps[0] is the newest
    comp_pkg::sample_t neg [WINDOW_DEPTH];          // Negated taps
    comp_pkg::mag_t node [NODES];                   // Comparison tree, node 0 is the root
    comp_pkg::mag_t diff [WINDOW_DEPTH-1];          // Left child minus right child

    // Shift chain, a new sample enters every clock
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < WINDOW_DEPTH; i++) taps[i] <= '0;
        end else begin
            taps[0] <= sample;
            for (int i = 1; i < WINDOW_DEPTH; i++) taps[i] <= taps[i-1];
        end
    end

    // Magnitude of each tap fills the leaves
    for (genvar i = 0; i < WINDOW_DEPTH; i++) begin : g_mag
        cla_adder #(.WIDTH(16)) u_neg (
            .a   (~taps[i]),                        // Two's complement negate
            .b   (16'h0000),
            .cin (1'b1),
            .sum (neg[i])
        );
        assign node[WINDOW_DEPTH-1+i] = taps[i][15] ? neg[i] : taps[i];
    end

    // Pairwise reduction, children of node i are 2i+1 and 2i+2
    for (genvar i = 0; i < WINDOW_DEPTH - 1; i++) begin : g_cmp
        cla_adder #(.WIDTH(16)) u_sub (
            .a   (node[2*i+1]),
            .b   (~node[2*i+2]),
            .cin (1'b1),
            .sum (diff[i])
        );
        // Both inputs below 2**15, so the sign bit is the compare result
        assign node[i] = diff[i][15] ? node[2*i+2] : node[2*i+1];
    end

    assign oldest = taps[WINDOW_DEPTH-1];
    assign oldest_mag = node[NODES-1];              // Leaf of the last tap
    assign peak = node[0];

endmodule : window_peak

`default_nettype wire

// File: source/amp_comp.sv
// Per-channel amplitude compressor
`default_nettype none

module amp_comp #(
    parameter int WINDOW_DEPTH = 4                  // Window length in samples
) (
    input wire clk,
    input wire arst_n,
    input wire comp_pkg::sample_t inchan,           // Incoming sample
    input wire comp_pkg::thresh_t thresh,           // Shared threshold code
    output comp_pkg::sample_t outchan               // Oldest sample, compressed
);

    comp_pkg::sample_t oldest;                      // Sample leaving the window
    comp_pkg::mag_t oldest_mag;
    comp_pkg::mag_t peak;                           // Window maximum
    comp_pkg::mag_t thresh_word;                    // Threshold as a magnitude
    comp_pkg::mag_t excess;                         // peak - threshold, signed result
    logic [3:0] excess_bits;                        // Gain factor
    comp_pkg::product_t product;
    comp_pkg::mag_t modifier;                       // Amount pulled toward zero
    comp_pkg::sample_t out_pos;                     // oldest - modifier
    comp_pkg::sample_t out_neg;                     // oldest + modifier

    window_peak #(.WINDOW_DEPTH(WINDOW_DEPTH)) u_window (
        .clk        (clk),
        .arst_n     (arst_n),
        .sample     (inchan),
        .oldest     (oldest),
        .oldest_mag (oldest_mag),
        .peak       (peak)
    );

    assign thresh_word = comp_pkg::mag_t'(thresh) << comp_pkg::THRESH_LSB;

    cla_adder #(.WIDTH(16)) u_excess (
        .a   (peak),
        .b   (~thresh_word),                        // Subtract via invert plus carry
        .cin (1'b1),
        .sum (excess)
    );

    assign excess_bits = excess[comp_pkg::THRESH_LSB+3:comp_pkg::THRESH_LSB];

    gain_multiplier u_gain (
        .mag     (oldest_mag),
        .factor  (excess_bits),
        .product (product)
    );

    // Scale back down by the position of the peak's top bit
    always_comb begin
        if (excess[15]) begin
            modifier = '0;                          // Peak under threshold
        end else if (peak[14]) begin
            modifier = comp_pkg::mag_t'(product >> 15);
        end else if (peak[13]) begin
            modifier = comp_pkg::mag_t'(product >> 14);
        end else if (peak[12]) begin
            modifier = comp_pkg::mag_t'(product >> 13);
        end else if (peak[11]) begin
            modifier = comp_pkg::mag_t'(product >> 12);
        end else begin
            modifier = '0;                          // Quiet window
        end
    end

    cla_adder #(.WIDTH(16)) u_pull_pos (
        .a   (oldest),
        .b   (~modifier),
        .cin (1'b1),
        .sum (out_pos)
    );

    cla_adder #(.WIDTH(16)) u_pull_neg (
        .a   (oldest),
        .b   (modifier),
        .cin (1'b0),
        .sum (out_neg)
    );

    assign outchan = oldest[15] ? out_neg : out_pos;   // Always toward zero

endmodule : amp_comp

`default_nettype wire

// File: source/stereo_compressor.sv
// Stereo amplitude compressor
`default_nettype none

module stereo_compressor #(
    parameter int WINDOW_DEPTH = 4                  // Window length for both channels
) (
    input wire clk,
    input wire arst_n,
    input wire comp_pkg::sample_t left_in,          // Left PCM in
    input wire comp_pkg::sample_t right_in,         // Right PCM in
    input wire comp_pkg::thresh_t thresh,           // Shared by both channels
    output comp_pkg::sample_t left_out,             // Left, four samples later
    output comp_pkg::sample_t right_out             // Right, four samples later
);

    // Left channel
    amp_comp #(
        .WINDOW_DEPTH (WINDOW_DEPTH)
    ) left_comp (
        .clk     (clk),
        .arst_n  (arst_n),
        .inchan  (left_in),
        .thresh  (thresh),
        .outchan (left_out)
    );

    // Right channel, only the threshold is shared with the left
    amp_comp #(
        .WINDOW_DEPTH (WINDOW_DEPTH)
    ) right_comp (
        .clk     (clk),
        .arst_n  (arst_n),
        .inchan  (right_in),
        .thresh  (thresh),
        .outchan (right_out)
    );

endmodule : stereo_compressor

`default_nettype wire

// File: test/tb_stereo_compressor.sv
// Stereo compressor testbench
`default_nettype none

module tb_stereo_compressor;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH = 4;                       // Window taps and output latency
    localparam int CYCLE_LIMIT = 2000;              // About 3x the total test length
    localparam int LOUD_LEN = 12;

    logic clk;
    logic arst_n;
    comp_pkg::sample_t left_in;
    comp_pkg::sample_t right_in;
    comp_pkg::thresh_t thresh;
    comp_pkg::sample_t left_out;
    comp_pkg::sample_t right_out;

    comp_pkg::sample_t hist_l [DEPTH];              // Model window with [0] newest
    comp_pkg::sample_t hist_r [DEPTH];
    comp_pkg::sample_t cur_l;                       // Value now on the input ports
    comp_pkg::sample_t cur_r;
    int errors;
    int checks;
    int cycles;
    integer seed;
    int loud_seq [LOUD_LEN] = '{30000, -28000, 25000, -31000, 20000, 16000,
                                -17000, 9000, -5000, 3000, 1500, -32767};

    stereo_compressor #(.WINDOW_DEPTH(DEPTH)) dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .left_in   (left_in),
        .right_in  (right_in),
        .thresh    (thresh),
        .left_out  (left_out),
        .right_out (right_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                      // 10 ns period
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic int abs_val(input int v);
        return (v < 0) ? -v : v;
    endfunction

    // Expected output from the window contents and threshold
    function automatic int model_out(input comp_pkg::sample_t h [DEPTH], input int th);
        int mags [DEPTH];
        int peak;
        int excess;
        int factor;
        int modifier;
        peak = 0;
        for (int i = 0; i < DEPTH; i++) begin
            mags[i] = abs_val(h[i]);
            if (mags[i] > peak) peak = mags[i];
        end
        excess = peak - th * 2048;                  // Code k is k * 2048
        modifier = 0;
        if (excess >= 0) begin
            factor = (excess / 2048) % 16;          // Excess bits 14..11
            if (peak >= 16384) modifier = (mags[DEPTH-1] * factor) / 32768;
            else if (peak >= 8192) modifier = (mags[DEPTH-1] * factor) / 16384;
            else if (peak >= 4096) modifier = (mags[DEPTH-1] * factor) / 8192;
            else if (peak >= 2048) modifier = (mags[DEPTH-1] * factor) / 4096;
        end
        if (h[DEPTH-1] < 0) return h[DEPTH-1] + modifier;    // Toward zero from below
        return h[DEPTH-1] - modifier;
    endfunction

    task automatic check(input string name, input int expected, input int actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // One sample per channel and a compare of both outputs with the model
    task automatic step_and_check(input int l, input int r, input int th, input string name);
        @(posedge clk);
        if (arst_n) begin                           // DUT window shifts on this edge
            for (int i = DEPTH - 1; i > 0; i--) begin
                hist_l[i] = hist_l[i-1];
                hist_r[i] = hist_r[i-1];
            end
            hist_l[0] = cur_l;
            hist_r[0] = cur_r;
        end
        left_in <= comp_pkg::sample_t'(l);
        right_in <= comp_pkg::sample_t'(r);
        thresh <= comp_pkg::thresh_t'(th);
        cur_l = comp_pkg::sample_t'(l);
        cur_r = comp_pkg::sample_t'(r);
        @(negedge clk);                             // Outputs settled mid cycle
        check({name, "_left"}, model_out(hist_l, th), left_out);
        check({name, "_right"}, model_out(hist_r, th), right_out);
    endtask

    task automatic reset_test();
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            left_in <= comp_pkg::sample_t'(1234 + i);    // Nonzero while in reset
            right_in <= comp_pkg::sample_t'(-4321 - i);
            thresh <= 4'd3;
            @(negedge clk);
            check("reset_hold_left", 0, left_out);
            check("reset_hold_right", 0, right_out);
        end
        @(posedge clk);
        arst_n <= 1'b1;
        left_in <= 16'sd777;
        right_in <= -16'sd777;
        cur_l = 16'sd777;
        cur_r = -16'sd777;
        @(negedge clk);
        check("reset_release_left", 0, left_out);     // Taps still clear
        check("reset_release_right", 0, right_out);
    endtask

    task automatic passthrough_test();
        int sent [$];
        int v;
        for (int i = 0; i < 20; i++) begin
            v = (i * 2900) % 30000;
            if (i % 2 == 1) v = -v;
            step_and_check(v, -v, 15, "passthrough");
            sent.push_back(v);
            if (sent.size() > DEPTH) begin          // Window holds only new samples
                check("passthrough_delay_left", sent[sent.size()-DEPTH-1], left_out);
                check("passthrough_delay_right", -sent[sent.size()-DEPTH-1], right_out);
            end
        end
    endtask

    task automatic compression_test();
        int old_l;
        for (int i = 0; i < LOUD_LEN; i++) begin
            step_and_check(loud_seq[i], -loud_seq[LOUD_LEN-1-i], 2, "compress");
            old_l = hist_l[DEPTH-1];
            check("compress_no_growth", 1, int'(abs_val(left_out) <= abs_val(old_l)));
            check("compress_sign_kept", 1,
                  int'((old_l >= 0) ? (left_out >= 0) : (left_out <= 0)));
        end
    endtask

    task automatic sweep_test();
        int ths [4] = '{8, 5, 2, 0};                // Falling threshold order
        int prev_mag [LOUD_LEN];                    // Model magnitude at the higher threshold
        int mag;
        for (int p = 0; p < 4; p++) begin
            for (int i = 0; i < DEPTH; i++) step_and_check(0, 0, ths[p], "sweep_flush");
            for (int i = 0; i < LOUD_LEN; i++) begin
                step_and_check(loud_seq[i], loud_seq[i], ths[p], "sweep");
                mag = abs_val(left_out);
                if (p > 0) check("sweep_monotonic", 1, int'(mag <= prev_mag[i]));
                prev_mag[i] = abs_val(model_out(hist_l, ths[p]));
            end
        end
    endtask

    task automatic independence_test();
        int quiet_q [$];
        int quiet;
        for (int i = 0; i < LOUD_LEN; i++) begin   // Loud left and quiet right
            quiet = i * 300 - 1500;
            step_and_check(loud_seq[i], quiet, 2, "indep_lr");
            quiet_q.push_back(quiet);
            if (quiet_q.size() > DEPTH) check("indep_right_delay",
                                              quiet_q[quiet_q.size()-DEPTH-1], right_out);
        end
        quiet_q.delete();
        for (int i = 0; i < LOUD_LEN; i++) begin   // Roles swapped
            quiet = 1700 - i * 250;
            step_and_check(quiet, loud_seq[i], 2, "indep_rl");
            quiet_q.push_back(quiet);
            if (quiet_q.size() > DEPTH) check("indep_left_delay",
                                              quiet_q[quiet_q.size()-DEPTH-1], left_out);
        end
    endtask

    task automatic random_test();
        int r;
        int l;
        int rt;
        int th;
        for (int i = 0; i < 500; i++) begin
            r = $random(seed);
            l = $signed(r[15:0]);
            if (l == -32768) l = -32767;            // Full-scale negative unsupported
            r = $random(seed);
            rt = $signed(r[15:0]);
            if (rt == -32768) rt = -32767;
            r = $random(seed);
            th = int'(r[3:0]);
            step_and_check(l, rt, th, "random");
        end
    endtask

    initial begin
        arst_n = 1'b0;
        left_in = '0;
        right_in = '0;
        thresh = '0;
        cur_l = '0;
        cur_r = '0;
        errors = 0;
        checks = 0;
        cycles = 0;
        seed = 64;
        for (int i = 0; i < DEPTH; i++) begin
            hist_l[i] = '0;
            hist_r[i] = '0;
        end
        reset_test();
        passthrough_test();
        compression_test();
        sweep_test();
        independence_test();
        random_test();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_stereo_compressor

`default_nettype wire

// File: project.f
source/comp_pkg.sv
source/cla_adder.sv
source/gain_multiplier.sv
source/window_peak.sv
source/amp_comp.sv
source/stereo_compressor.sv
test/tb_stereo_compressor.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the stereo compressor testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    --top-module tb_stereo_compressor \
    -f project.f \
    -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "^Verification passed$" sim.log \
    && echo "Result: PASS" \
    || { echo "Result: FAIL"; exit 1; }
